/* filelist.f */
verilog/imuldiv_pkg.sv
verilog/imuldiv_iter_ctrl.sv
verilog/imuldiv_mul_dpath.sv
verilog/imuldiv_div_dpath.sv
verilog/imuldiv_top.sv
bench/imuldiv_checker.sv
bench/imuldiv_tb.sv

/* Bender.yml */
package:
  name: imuldiv

sources:
  - files:
      - verilog/imuldiv_pkg.sv
      - verilog/imuldiv_iter_ctrl.sv
      - verilog/imuldiv_mul_dpath.sv
      - verilog/imuldiv_div_dpath.sv
      - verilog/imuldiv_top.sv
  - target: test
    files:
      - bench/imuldiv_checker.sv
      - bench/imuldiv_tb.sv

/* bench/imuldiv_tb.sv */
/* random requests with gaps and response back-pressure, fixed seed
   back-pressure runs are capped at max_stall low cycles */
`timescale 1ns/1ps
`default_nettype none

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam int num_directed = 6;
  localparam int num_random = 400;
  localparam int num_total = num_directed + num_random;
  localparam int max_gap = 3;
  localparam int max_stall = 8;
  // worst case per request plus reset and drain margin
  localparam int timeout_cycles = num_total * (iter_count + 1 + max_gap + max_stall) + 200;

  logic clk = 1'b0;
  logic reset;
  imuldiv_req_t req;
  logic req_val;
  logic req_rdy;
  logic [dword_w-1:0] resp_result;
  logic resp_val;
  logic resp_rdy;

  int value_errors;
  int protocol_errors;
  int accepted;
  int responded;

  // separate streams so stimulus and back-pressure never share state
  logic [31:0] stim_rng = 32'h3cbf;
  logic [31:0] bp_rng = 32'h3cbf ^ 32'hb5a7_0000;
  int stall_run = 0;

  always #10 clk = ~clk;

  imuldiv_top u_imuldiv_top (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  imuldiv_checker u_checker (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .req_val         (req_val),
    .req_rdy         (req_rdy),
    .resp_result     (resp_result),
    .resp_val        (resp_val),
    .resp_rdy        (resp_rdy),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors),
    .accepted        (accepted),
    .responded       (responded)
  );

  // --------------------------------------------------
  // random helpers
  // --------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // about one operand in five is a corner value
  task automatic pick_operand(output logic [31:0] v);
    logic [31:0] r;
    stim_rng = xorshift(stim_rng);
    r = stim_rng;
    if (r % 5 == 0) begin
      case ((r >> 8) % 5)
        0:       v = 32'h0000_0000;
        1:       v = 32'h0000_0001;
        2:       v = 32'hffff_ffff;
        3:       v = 32'h8000_0000;
        default: v = 32'h7fff_ffff;
      endcase
    end else begin
      stim_rng = xorshift(stim_rng);
      v = stim_rng;
    end
  endtask

  // called on a falling edge, rdy is settled then since it follows state only
  task automatic send_request(input imuldiv_fn_e fn, input logic [31:0] a,
                              input logic [31:0] b);
    req.fn = fn;
    req.a = a;
    req.b = b;
    req_val = 1'b1;
    while (!req_rdy) @(negedge clk);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // --------------------------------------------------
  // back-pressure, a low run never exceeds max_stall
  // --------------------------------------------------

  always @(negedge clk) begin
    bp_rng = xorshift(bp_rng);
    if ((stall_run < max_stall) && (bp_rng[1:0] == 2'b00)) begin
      resp_rdy = 1'b0;
      stall_run = stall_run + 1;
    end else begin
      resp_rdy = 1'b1;
      stall_run = 0;
    end
  end

  // --------------------------------------------------
  // stimulus and final report
  // --------------------------------------------------

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    imuldiv_fn_e fn;
    reset = 1'b1;
    req = '0;
    req_val = 1'b0;
    resp_rdy = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // corner cases that random draws rarely pair up
    send_request(FN_MUL, 32'h8000_0000, 32'h8000_0000);
    send_request(FN_MUL, 32'h8000_0000, 32'hffff_ffff);
    send_request(FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    send_request(FN_DIV, 32'hffff_fff9, 32'h0000_0000);
    send_request(FN_DIVU, 32'h1234_5678, 32'h0000_0000);
    send_request(FN_DIV, 32'hffff_fff9, 32'h0000_0002);
    for (int i = 0; i < num_random; i++) begin
      stim_rng = xorshift(stim_rng);
      r = stim_rng;
      case (r % 3)
        0:       fn = FN_MUL;
        1:       fn = FN_DIV;
        default: fn = FN_DIVU;
      endcase
      pick_operand(a);
      pick_operand(b);
      send_request(fn, a, b);
      repeat ((r >> 4) % (max_gap + 1)) @(negedge clk);
    end
    while (responded < num_total) @(negedge clk);
    // a few extra cycles to catch a stray response
    repeat (4) @(negedge clk);
    if (accepted != responded) begin
      $display("%0d accepted requests never got a response", accepted - responded);
    end
    $display("accepted %0d, responses %0d, value errors %0d, protocol errors %0d",
             accepted, responded, value_errors, protocol_errors);
    if ((value_errors == 0) && (protocol_errors == 0) &&
        (accepted == num_total) && (responded == num_total)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: responses stopped arriving, %0d of %0d received",
             responded, num_total);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/imuldiv_checker.sv */
/* passive checker on the imuldiv_top ports, samples on the rising edge
   expected results come from plain integer arithmetic on the request */
`timescale 1ns/1ps
`default_nettype none

module imuldiv_checker
  import imuldiv_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  imuldiv_req_t       req,
  input  logic               req_val,
  input  logic               req_rdy,
  input  logic [dword_w-1:0] resp_result,
  input  logic               resp_val,
  input  logic               resp_rdy,
  output int                 value_errors,
  output int                 protocol_errors,
  output int                 accepted,
  output int                 responded
);

  // requests accepted but not yet answered
  imuldiv_req_t pend_q[$];
  imuldiv_req_t exp_req;
  logic [dword_w-1:0] exp_val;

  // previous-edge copies for the hold and rise checks
  logic reset_q;
  logic resp_val_q;
  logic resp_rdy_q;
  logic [dword_w-1:0] result_q;
  logic busy;
  int cycle;
  int accept_cycle;

  function automatic string fn_label(input imuldiv_fn_e fn);
    case (fn)
      FN_MUL:  return "mul";
      FN_DIV:  return "div";
      default: return "divu";
    endcase
  endfunction

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------

  function automatic logic [dword_w-1:0] expected_result(input imuldiv_req_t r);
    logic [dword_w-1:0] prod;
    longint sa;
    longint sb;
    longint lq;
    longint lr;
    case (r.fn)
      FN_MUL: begin
        // sign-extended operands, product taken modulo 2^64
        prod = {{word_w{r.a[word_w-1]}}, r.a} * {{word_w{r.b[word_w-1]}}, r.b};
        return prod;
      end
      FN_DIV: begin
        // zero divisor: quotient of all ones, negated for a negative dividend
        if (r.b == '0) begin
          return {r.a, (r.a[word_w-1] ? 32'h0000_0001 : 32'hffff_ffff)};
        end
        sa = $signed(r.a);
        sb = $signed(r.b);
        // 64-bit math keeps min / -1 exact, low half wraps to min again
        lq = sa / sb;
        lr = sa % sb;
        return {lr[word_w-1:0], lq[word_w-1:0]};
      end
      default: begin
        if (r.b == '0) begin
          return {r.a, 32'hffff_ffff};
        end
        return {r.a % r.b, r.a / r.b};
      end
    endcase
  endfunction

  // --------------------------------------------------
  // per-edge checks
  // --------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      pend_q.delete();
      value_errors    = 0;
      protocol_errors = 0;
      accepted        = 0;
      responded       = 0;
      busy            = 1'b0;
      cycle           = 0;
      accept_cycle    = 0;
      resp_val_q      = 1'b0;
      resp_rdy_q      = 1'b0;
      result_q        = '0;
    end else begin
      cycle = cycle + 1;
      if (reset_q && resp_val) begin
        $display("protocol error: resp_val is high right after reset");
        protocol_errors = protocol_errors + 1;
      end
      // only one operation in flight, rdy tracks it exactly
      if (busy && req_rdy) begin
        $display("protocol error at cycle %0d: req_rdy high while busy", cycle);
        protocol_errors = protocol_errors + 1;
      end
      if (!busy && !req_rdy) begin
        $display("protocol error at cycle %0d: req_rdy low while idle", cycle);
        protocol_errors = protocol_errors + 1;
      end
      if (resp_val && (pend_q.size() == 0)) begin
        $display("protocol error at cycle %0d: response with no request pending", cycle);
        protocol_errors = protocol_errors + 1;
      end
      // first cycle of resp_val, load cycle plus the calc steps
      if (resp_val && !resp_val_q && (cycle - accept_cycle != iter_count + 1)) begin
        $display("FAILED latency #%0d: expected %0d, actual %0d",
                 responded, iter_count + 1, cycle - accept_cycle);
        protocol_errors = protocol_errors + 1;
      end
      // back-pressure must freeze the response
      if (resp_val_q && !resp_rdy_q && (!resp_val || (resp_result !== result_q))) begin
        $display("FAILED hold #%0d: expected %h, actual %h (resp_val %b)",
                 responded, result_q, resp_result, resp_val);
        protocol_errors = protocol_errors + 1;
      end
      // response transfer
      if (resp_val && resp_rdy && (pend_q.size() != 0)) begin
        exp_req = pend_q.pop_front();
        exp_val = expected_result(exp_req);
        if (resp_result !== exp_val) begin
          $display("FAILED %s #%0d a=%h b=%h: expected %h, actual %h",
                   fn_label(exp_req.fn), responded, exp_req.a, exp_req.b,
                   exp_val, resp_result);
          value_errors = value_errors + 1;
        end
        responded = responded + 1;
        busy = 1'b0;
      end
      // request transfer
      if (req_val && req_rdy) begin
        pend_q.push_back(req);
        accept_cycle = cycle;
        accepted = accepted + 1;
        busy = 1'b1;
      end
      resp_val_q = resp_val;
      resp_rdy_q = resp_rdy;
      result_q   = resp_result;
    end
    reset_q = reset;
  end

endmodule

`default_nettype wire

/* verilog/imuldiv_top.sv */
/* mul/div unit, one operation in flight at a time
   fixed latency of one load cycle plus iter_count calc cycles */
`timescale 1ns/1ps
`default_nettype none

module imuldiv_top
  import imuldiv_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  imuldiv_req_t       req,
  input  logic               req_val,
  output logic               req_rdy,
  output logic [dword_w-1:0] resp_result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  logic is_mul;

  // multiply side
  logic               mul_req_val;
  logic               mul_req_rdy;
  logic               mul_resp_val;
  logic               mul_load;
  logic               mul_step;
  logic [dword_w-1:0] mul_result;

  // divide side
  logic               div_req_val;
  logic               div_req_rdy;
  logic               div_resp_val;
  logic               div_load;
  logic               div_step;
  logic [dword_w-1:0] div_result;

  // --------------------------------------------------
  // request steering
  // --------------------------------------------------

  assign is_mul = (req.fn == FN_MUL);

  // accept only when neither unit is busy
  assign req_rdy = mul_req_rdy & div_req_rdy;

  // gate with req_rdy so an idle unit cannot start while the other runs
  assign mul_req_val = req_val & req_rdy & is_mul;
  assign div_req_val = req_val & req_rdy & ~is_mul;

  // --------------------------------------------------
  // units
  // --------------------------------------------------

  imuldiv_iter_ctrl u_mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (resp_rdy),
    .load     (mul_load),
    .step     (mul_step)
  );

  imuldiv_mul_dpath u_mul_dpath (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .load   (mul_load),
    .step   (mul_step),
    .result (mul_result)
  );

  imuldiv_iter_ctrl u_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (resp_rdy),
    .load     (div_load),
    .step     (div_step)
  );

  imuldiv_div_dpath u_div_dpath (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .load   (div_load),
    .step   (div_step),
    .result (div_result)
  );

  // --------------------------------------------------
  // response merge
  // --------------------------------------------------

  // at most one unit sits in done at a time
  assign resp_val    = mul_resp_val | div_resp_val;
  assign resp_result = mul_resp_val ? mul_result : div_result;

endmodule

`default_nettype wire

/* verilog/imuldiv_div_dpath.sv */
/* restoring divide, signed for FN_DIV and unsigned otherwise
   result is {remainder, quotient}, divide by zero is not trapped */
`timescale 1ns/1ps
`default_nettype none

module imuldiv_div_dpath
  import imuldiv_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  imuldiv_req_t       req,
  input  logic               load,
  input  logic               step,
  output logic [dword_w-1:0] result
);

  // operation flags captured at load
  logic signed_op;
  logic sign_a;
  logic sign_b;

  // divisor magnitude, partial remainder, dividend/quotient shifter
  logic [word_w-1:0] divisor;
  logic [word_w-1:0] rem;
  logic [word_w-1:0] quo;

  logic              in_signed;
  logic [word_w-1:0] mag_a;
  logic [word_w-1:0] mag_b;

  // one restoring step
  logic [word_w:0]   shifted;
  logic [word_w+1:0] diff;
  logic              fits;

  // fix-up of the final values
  logic [word_w-1:0] quo_out;
  logic [word_w-1:0] rem_out;

  // --------------------------------------------------
  // operand handling
  // --------------------------------------------------

  assign in_signed = (req.fn == FN_DIV);

  // unsigned divide takes operands as they are
  assign mag_a = (in_signed && req.a[word_w-1]) ? (~req.a + 1'b1) : req.a;
  assign mag_b = (in_signed && req.b[word_w-1]) ? (~req.b + 1'b1) : req.b;

  always_ff @(posedge clk) begin
    if (reset) begin
      signed_op <= 1'b0;
      sign_a    <= 1'b0;
      sign_b    <= 1'b0;
    end else if (load) begin
      signed_op <= in_signed;
      sign_a    <= in_signed & req.a[word_w-1];
      sign_b    <= in_signed & req.b[word_w-1];
    end
  end

  // --------------------------------------------------
  // restoring step
  // --------------------------------------------------

  // next dividend bit comes off the top of the quotient shifter
  assign shifted = {rem, quo[word_w-1]};
  // extra top bit is the borrow
  assign diff    = {1'b0, shifted} - {2'b00, divisor};
  assign fits    = ~diff[word_w+1];

  always_ff @(posedge clk) begin
    if (load) begin
      divisor <= mag_b;
      rem     <= '0;
      quo     <= mag_a;
    end else if (step) begin
      // remainder stays below the divisor so the low bits are enough
      rem <= fits ? diff[word_w-1:0] : shifted[word_w-1:0];
      quo <= {quo[word_w-2:0], fits};
    end
  end

  // --------------------------------------------------
  // sign fix-up and packing
  // --------------------------------------------------

  // quotient truncates toward zero, remainder follows the dividend
  assign quo_out = (signed_op && (sign_a ^ sign_b)) ? (~quo + 1'b1) : quo;
  assign rem_out = (signed_op && sign_a) ? (~rem + 1'b1) : rem;

  assign result = {rem_out, quo_out};

endmodule

`default_nettype wire

/* verilog/imuldiv_mul_dpath.sv */
/* signed 32x32 multiply by shift and add on operand magnitudes
   result is valid only after all steps have run since load */
`timescale 1ns/1ps
`default_nettype none

module imuldiv_mul_dpath
  import imuldiv_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  imuldiv_req_t       req,
  input  logic               load,
  input  logic               step,
  output logic [dword_w-1:0] result
);

  // operand signs captured at load
  logic sign_a;
  logic sign_b;

  // shifting operands and running sum
  logic [dword_w-1:0] mcand;
  logic [word_w-1:0]  mplier;
  logic [dword_w-1:0] acc;

  // magnitudes of the incoming operands
  logic [word_w-1:0] mag_a;
  logic [word_w-1:0] mag_b;

  // --------------------------------------------------
  // operand unsigning
  // --------------------------------------------------

  // most negative value maps onto itself, which is the right magnitude
  assign mag_a = req.a[word_w-1] ? (~req.a + 1'b1) : req.a;
  assign mag_b = req.b[word_w-1] ? (~req.b + 1'b1) : req.b;

  // --------------------------------------------------
  // sign flags
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
    end else if (load) begin
      sign_a <= req.a[word_w-1];
      sign_b <= req.b[word_w-1];
    end
  end

  // --------------------------------------------------
  // shift and add
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{word_w{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
    end else if (step) begin
      // add the multiplicand for every set multiplier bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // product of two magnitudes fits 64 bits, even for min times min
  assign result = (sign_a ^ sign_b) ? (~acc + 1'b1) : acc;

endmodule

`default_nettype wire

/* verilog/imuldiv_iter_ctrl.sv */
/* iterative sequencer, one load cycle then iter_count step cycles
   req_rdy and resp_val depend on state only */
`timescale 1ns/1ps
`default_nettype none

module imuldiv_iter_ctrl
  import imuldiv_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step
);

  // last value of the step counter before leaving calc
  localparam logic [cnt_w-1:0] last_step = cnt_w'(iter_count - 1);

  iter_state_e state;
  logic [cnt_w-1:0] count;

  // --------------------------------------------------
  // state register and step counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          // accepted request, operands are captured on this same edge
          if (req_val && req_rdy) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // counter wraps back to zero on the last step
          count <= count + 1'b1;
          if (count == last_step) begin
            state <= DONE;
          end
        end
        DONE: begin
          // hold the result until the consumer takes it
          if (resp_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // outputs
  // --------------------------------------------------

  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);
  // load is only a single cycle since the fsm leaves idle right after
  assign load     = req_val && req_rdy;
  assign step     = (state == CALC);

endmodule

`default_nettype wire

/* verilog/imuldiv_pkg.sv */
/* shared types and widths for the iterative mul/div unit
   operand width is fixed at 32 bits and the step count at 32 */
`default_nettype none

package imuldiv_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------

  // operand width, results are twice this
  localparam int word_w = 32;
  localparam int dword_w = 2 * word_w;

  // one calc step per operand bit
  localparam int iter_count = 32;
  localparam int cnt_w = $clog2(iter_count);

  // --------------------------------------------------
  // enums
  // --------------------------------------------------

  // opcode, anything that is not FN_MUL is routed to the divider
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } imuldiv_fn_e;

  // sequencing states of the iterative controller
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } iter_state_e;

  // request message, fn in the top bits
  typedef struct packed {
    imuldiv_fn_e       fn;
    logic [word_w-1:0] a;
    logic [word_w-1:0] b;
  } imuldiv_req_t;

endpackage

`default_nettype wire
